// File: source/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Lane geometry and bus sizes
`define DMA_NUM_LANES       4
`define DMA_LANE_WIDTH      16
`define DMA_LANE_ADDR_WIDTH 8
`define DMA_BUS_ADDR_WIDTH  32
`define DMA_BUS_WIDTH       (`DMA_NUM_LANES * `DMA_LANE_WIDTH)
`define DMA_BEAT_BYTES      (`DMA_BUS_WIDTH / 8)
`define DMA_BANK_DEPTH      256

// Register map, byte offsets on the AXI4-Lite port
`define DMA_REG_MEM_ADDR    8'h00
`define DMA_REG_LANE_ADDR   8'h04
`define DMA_REG_NUM_BYTES   8'h08
`define DMA_REG_CTRL        8'h0C
`define DMA_REG_STATUS      8'h10

`endif

// File: source/dma_pkg.sv
`include "dma_params.svh"

package dma_pkg;

  // ========================================
  // Vector types
  // ========================================
  typedef logic [`DMA_BUS_ADDR_WIDTH-1:0]  bus_addr_t;
  typedef logic [`DMA_LANE_ADDR_WIDTH-1:0] lane_addr_t;
  typedef logic [15:0]                     byte_count_t;
  typedef logic [`DMA_LANE_WIDTH-1:0]      lane_word_t;
  typedef logic [`DMA_BUS_WIDTH-1:0]       bus_word_t;
  typedef logic [7:0]                      cmd_count_t;

  // ========================================
  // Command and request bundles
  // ========================================
  typedef struct packed {
    bus_addr_t   mem_addr;
    lane_addr_t  lane_addr;
    byte_count_t num_bytes;
    // Set for lanes to memory
    logic        store;
  } dma_cmd_t;

  typedef struct packed {
    bus_addr_t                   address;
    bus_word_t                   writedata;
    logic [`DMA_BEAT_BYTES-1:0]  byteen;
    logic                        en;
    logic                        wren;
  } dbus_req_t;

  // One address for all banks, each bank takes its own slice of wrdata
  typedef struct packed {
    lane_addr_t addr;
    logic       wren;
    logic       rden;
    bus_word_t  wrdata;
  } lane_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_REQ,
    READ_WAIT,
    LOAD_DATA,
    UPDATE_RD,
    STORE_REQ,
    WRITE_WAIT,
    UPDATE_WR
  } dma_state_e;

endpackage

// File: source/dma_csr.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dma_csr (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [7:0]           s_axil_awaddr,
  input  logic                 s_axil_awvalid,
  output logic                 s_axil_awready,
  input  logic [31:0]          s_axil_wdata,
  input  logic [3:0]           s_axil_wstrb,
  input  logic                 s_axil_wvalid,
  output logic                 s_axil_wready,
  output logic [1:0]           s_axil_bresp,
  output logic                 s_axil_bvalid,
  input  logic                 s_axil_bready,
  input  logic [7:0]           s_axil_araddr,
  input  logic                 s_axil_arvalid,
  output logic                 s_axil_arready,
  output logic [31:0]          s_axil_rdata,
  output logic [1:0]           s_axil_rresp,
  output logic                 s_axil_rvalid,
  input  logic                 s_axil_rready,
  input  logic                 busy,
  input  logic                 done,
  input  dma_pkg::cmd_count_t  cmd_count,
  output dma_pkg::dma_cmd_t    cmd,
  output logic                 cmd_start,
  output logic                 done_clear
);
  import dma_pkg::*;

  bus_addr_t   mem_addr_q;
  lane_addr_t  lane_addr_q;
  byte_count_t num_bytes_q;
  logic        store_q;
  logic        wr_fire;
  logic        rd_fire;
  logic        start_req;
  logic [31:0] status_word;

  function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] merged;
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = strb[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
    end
    return merged;
  endfunction

  // A channel stays closed while its response is still pending
  assign s_axil_awready = ~s_axil_bvalid;
  assign s_axil_wready  = ~s_axil_bvalid;
  assign s_axil_arready = ~s_axil_rvalid;

  assign wr_fire     = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign rd_fire     = s_axil_arvalid && !s_axil_rvalid;
  assign start_req   = s_axil_wstrb[0] && s_axil_wdata[0];
  assign status_word = {16'b0, cmd_count, 6'b0, done, busy};

  assign cmd.mem_addr  = mem_addr_q;
  assign cmd.lane_addr = lane_addr_q;
  assign cmd.num_bytes = num_bytes_q;
  assign cmd.store     = store_q;

  // ========================================
  // Write path
  // ========================================
  always_ff @(posedge clk) begin
    if (!resetn) begin
      s_axil_bvalid <= 1'b0;
      cmd_start     <= 1'b0;
      done_clear    <= 1'b0;
      mem_addr_q    <= '0;
      lane_addr_q   <= '0;
      num_bytes_q   <= '0;
      store_q       <= 1'b0;
    end else begin
      cmd_start  <= 1'b0;
      done_clear <= 1'b0;
      if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (wr_fire) begin
        s_axil_bvalid <= 1'b1;
        s_axil_bresp  <= 2'b00;
        case (s_axil_awaddr)
          `DMA_REG_MEM_ADDR: begin
            mem_addr_q <= merge_strb(mem_addr_q, s_axil_wdata, s_axil_wstrb);
          end
          `DMA_REG_LANE_ADDR: begin
            lane_addr_q <= lane_addr_t'(merge_strb(32'(lane_addr_q), s_axil_wdata,
                                                   s_axil_wstrb));
          end
          `DMA_REG_NUM_BYTES: begin
            num_bytes_q <= byte_count_t'(merge_strb(32'(num_bytes_q), s_axil_wdata,
                                                    s_axil_wstrb));
          end
          `DMA_REG_CTRL: begin
            // Only one command runs at a time
            if (start_req && busy) begin
              s_axil_bresp <= 2'b10;
            end else begin
              cmd_start <= start_req;
              if (s_axil_wstrb[0]) begin
                store_q <= s_axil_wdata[1];
              end
            end
          end
          `DMA_REG_STATUS: begin
            done_clear <= s_axil_wstrb[0] && s_axil_wdata[1];
          end
          default: begin
            s_axil_bresp <= 2'b10;
          end
        endcase
      end
    end
  end

  // ========================================
  // Read path
  // ========================================
  always_ff @(posedge clk) begin
    if (!resetn) begin
      s_axil_rvalid <= 1'b0;
    end else begin
      if (s_axil_rvalid && s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
      if (rd_fire) begin
        s_axil_rvalid <= 1'b1;
        s_axil_rresp  <= 2'b00;
        case (s_axil_araddr)
          `DMA_REG_MEM_ADDR:  s_axil_rdata <= mem_addr_q;
          `DMA_REG_LANE_ADDR: s_axil_rdata <= 32'(lane_addr_q);
          `DMA_REG_NUM_BYTES: s_axil_rdata <= 32'(num_bytes_q);
          `DMA_REG_CTRL:      s_axil_rdata <= {30'b0, store_q, 1'b0};
          `DMA_REG_STATUS:    s_axil_rdata <= status_word;
          default: begin
            s_axil_rdata <= '0;
            s_axil_rresp <= 2'b10;
          end
        endcase
      end
    end
  end

endmodule

// File: source/dma_engine.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dma_engine (
  input  logic                clk,
  input  logic                resetn,
  input  dma_pkg::dma_cmd_t   cmd,
  input  logic                cmd_start,
  output logic                busy,
  output logic                cmd_done,
  output dma_pkg::dbus_req_t  dbus_req,
  input  dma_pkg::bus_word_t  dbus_readdata,
  input  logic                dbus_wait,
  input  logic                dbus_data_valid,
  output dma_pkg::lane_req_t  lane_req,
  input  dma_pkg::bus_word_t  lane_rddata
);
  import dma_pkg::*;

  dma_state_e  state;
  dma_state_e  state_next;
  dma_cmd_t    cmd_q;
  byte_count_t count;
  lane_addr_t  beat;
  logic        more_beats;
  logic        data_held;
  logic        wr_issued;
  logic        bank_write;
  bus_word_t   rd_data;
  bus_word_t   wr_data;

  assign busy       = (state != IDLE);
  assign more_beats = (count != cmd_q.num_bytes);
  // Read data may come while still in READ_WAIT, then it is written from rd_data
  assign bank_write = (state == LOAD_DATA) && (dbus_data_valid || data_held);

  // ========================================
  // State machine
  // ========================================
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (cmd_start) begin
          state_next = cmd.store ? STORE_REQ : LOAD_REQ;
        end
      end
      LOAD_REQ:   state_next = more_beats ? READ_WAIT : IDLE;
      READ_WAIT: begin
        if (!dbus_wait) begin
          state_next = LOAD_DATA;
        end
      end
      LOAD_DATA: begin
        if (bank_write) begin
          state_next = UPDATE_RD;
        end
      end
      UPDATE_RD:  state_next = LOAD_REQ;
      STORE_REQ:  state_next = more_beats ? WRITE_WAIT : IDLE;
      WRITE_WAIT: begin
        // Wait can only rise the cycle after en, so never leave on the issue cycle
        if (wr_issued && !dbus_wait) begin
          state_next = UPDATE_WR;
        end
      end
      UPDATE_WR:  state_next = STORE_REQ;
      default:    state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= IDLE;
      cmd_done  <= 1'b0;
      data_held <= 1'b0;
      wr_issued <= 1'b0;
      count     <= '0;
      beat      <= '0;
    end else begin
      state    <= state_next;
      cmd_done <= (state inside {LOAD_REQ, STORE_REQ}) && !more_beats;
      case (state)
        IDLE: begin
          count <= '0;
          beat  <= '0;
        end
        READ_WAIT: begin
          if (dbus_data_valid) begin
            data_held <= 1'b1;
          end
        end
        WRITE_WAIT: wr_issued <= 1'b1;
        UPDATE_RD, UPDATE_WR: begin
          count     <= count + byte_count_t'(`DMA_BEAT_BYTES);
          beat      <= beat + 1'b1;
          data_held <= 1'b0;
          wr_issued <= 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

  // ========================================
  // Command and data registers
  // ========================================
  always_ff @(posedge clk) begin
    if ((state == IDLE) && cmd_start) begin
      cmd_q <= cmd;
      // Whole beats only
      cmd_q.num_bytes <= cmd.num_bytes & ~byte_count_t'(`DMA_BEAT_BYTES - 1);
    end
    if ((state == READ_WAIT) && dbus_data_valid) begin
      rd_data <= dbus_readdata;
    end
    if ((state == WRITE_WAIT) && !wr_issued) begin
      wr_data <= lane_rddata;
    end
  end

  // ========================================
  // Bus and bank requests
  // ========================================
  always_comb begin
    dbus_req = '0;
    lane_req = '0;
    if (state != IDLE) begin
      dbus_req.address = cmd_q.mem_addr + bus_addr_t'(count);
      lane_req.addr    = cmd_q.lane_addr + beat;
    end
    case (state)
      LOAD_REQ: dbus_req.en = more_beats;
      LOAD_DATA: begin
        lane_req.wren   = bank_write;
        lane_req.wrdata = data_held ? rd_data : dbus_readdata;
      end
      STORE_REQ: lane_req.rden = more_beats;
      WRITE_WAIT: begin
        // Bank data is live on the issue cycle and held in wr_data after it
        dbus_req.en        = !wr_issued;
        dbus_req.wren      = !wr_issued;
        dbus_req.byteen    = '1;
        dbus_req.writedata = wr_issued ? wr_data : lane_rddata;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: source/dma_status.sv
`timescale 1ns/10ps

module dma_status (
  input  logic                clk,
  input  logic                resetn,
  input  logic                cmd_done,
  input  logic                done_clear,
  output logic                done,
  output dma_pkg::cmd_count_t cmd_count,
  output logic                irq
);

  // ========================================
  // Sticky done flag and command counter
  // ========================================
  always_ff @(posedge clk) begin
    if (!resetn) begin
      done      <= 1'b0;
      cmd_count <= '0;
    end else begin
      // A completion in the same cycle as a clear keeps done set
      if (cmd_done) begin
        done      <= 1'b1;
        cmd_count <= cmd_count + 1'b1;
      end else if (done_clear) begin
        done <= 1'b0;
      end
    end
  end

  // The interrupt is level, it stays up until software clears done
  assign irq = done;

endmodule

// File: source/lane_scratchpad.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module lane_scratchpad (
  input  logic               clk,
  input  dma_pkg::lane_req_t lane_req,
  output dma_pkg::bus_word_t lane_rddata
);
  import dma_pkg::*;

  // One single-port bank per lane, bank i owns slice i of the beat
  for (genvar i = 0; i < `DMA_NUM_LANES; i++) begin : g_bank
    lane_word_t mem [`DMA_BANK_DEPTH];
    lane_word_t rd_q;

    always_ff @(posedge clk) begin
      if (lane_req.wren) begin
        mem[lane_req.addr] <= lane_req.wrdata[i*`DMA_LANE_WIDTH +: `DMA_LANE_WIDTH];
      end
      if (lane_req.rden) begin
        rd_q <= mem[lane_req.addr];
      end
    end

    assign lane_rddata[i*`DMA_LANE_WIDTH +: `DMA_LANE_WIDTH] = rd_q;
  end

endmodule

// File: source/dma_subsystem.sv
`timescale 1ns/10ps

module dma_subsystem (
  input  logic               clk,
  input  logic               resetn,
  input  logic [7:0]         s_axil_awaddr,
  input  logic               s_axil_awvalid,
  output logic               s_axil_awready,
  input  logic [31:0]        s_axil_wdata,
  input  logic [3:0]         s_axil_wstrb,
  input  logic               s_axil_wvalid,
  output logic               s_axil_wready,
  output logic [1:0]         s_axil_bresp,
  output logic               s_axil_bvalid,
  input  logic               s_axil_bready,
  input  logic [7:0]         s_axil_araddr,
  input  logic               s_axil_arvalid,
  output logic               s_axil_arready,
  output logic [31:0]        s_axil_rdata,
  output logic [1:0]         s_axil_rresp,
  output logic               s_axil_rvalid,
  input  logic               s_axil_rready,
  output dma_pkg::dbus_req_t dbus_req,
  input  dma_pkg::bus_word_t dbus_readdata,
  input  logic               dbus_wait,
  input  logic               dbus_data_valid,
  output logic               irq
);
  import dma_pkg::*;

  dma_cmd_t   cmd;
  logic       cmd_start;
  logic       done_clear;
  logic       busy;
  logic       cmd_done;
  logic       done;
  cmd_count_t cmd_count;
  lane_req_t  lane_req;
  bus_word_t  lane_rddata;

  dma_csr u_dma_csr (
    .clk            (clk),
    .resetn         (resetn),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .busy           (busy),
    .done           (done),
    .cmd_count      (cmd_count),
    .cmd            (cmd),
    .cmd_start      (cmd_start),
    .done_clear     (done_clear)
  );

  dma_engine u_dma_engine (
    .clk             (clk),
    .resetn          (resetn),
    .cmd             (cmd),
    .cmd_start       (cmd_start),
    .busy            (busy),
    .cmd_done        (cmd_done),
    .dbus_req        (dbus_req),
    .dbus_readdata   (dbus_readdata),
    .dbus_wait       (dbus_wait),
    .dbus_data_valid (dbus_data_valid),
    .lane_req        (lane_req),
    .lane_rddata     (lane_rddata)
  );

  dma_status u_dma_status (
    .clk        (clk),
    .resetn     (resetn),
    .cmd_done   (cmd_done),
    .done_clear (done_clear),
    .done       (done),
    .cmd_count  (cmd_count),
    .irq        (irq)
  );

  lane_scratchpad u_lane_scratchpad (
    .clk         (clk),
    .lane_req    (lane_req),
    .lane_rddata (lane_rddata)
  );

endmodule

// File: sim/dbus_memory_model.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module dbus_memory_model (
  input  logic               clk,
  input  logic               resetn,
  input  dma_pkg::dbus_req_t dbus_req,
  output dma_pkg::bus_word_t dbus_readdata,
  output logic               dbus_wait,
  output logic               dbus_data_valid
);
  import dma_pkg::*;

  localparam int BYTE_BITS = $clog2(`DMA_BEAT_BYTES);
  localparam int MEM_WORDS = 1024;

  bus_word_t   mem [MEM_WORDS];
  int unsigned req_count;
  logic [1:0]  wait_left;
  logic        rd_pending;
  logic [9:0]  rd_index;

  function automatic logic [9:0] word_index(input bus_addr_t addr);
    return addr[BYTE_BITS +: 10];
  endfunction

  task automatic preload(input bus_addr_t addr, input bus_word_t data);
    mem[word_index(addr)] = data;
  endtask

  function automatic bus_word_t peek(input bus_addr_t addr);
    return mem[word_index(addr)];
  endfunction

  // Untouched words hold their own byte address and its inverse
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {32'(i) << BYTE_BITS, ~(32'(i) << BYTE_BITS)};
    end
  end

  // ========================================
  // Request handling with 0 to 3 wait cycles
  // ========================================
  always @(posedge clk) begin : req_proc
    logic [1:0] delay;
    if (!resetn) begin
      dbus_wait       <= 1'b0;
      dbus_data_valid <= 1'b0;
      dbus_readdata   <= '0;
      wait_left       <= '0;
      rd_pending      <= 1'b0;
      rd_index        <= '0;
      req_count       <= 0;
    end else begin
      dbus_data_valid <= 1'b0;
      if (dbus_req.en) begin
        delay     = 2'($urandom % 4);
        req_count <= req_count + 1;
        rd_index  <= word_index(dbus_req.address);
        wait_left <= delay;
        dbus_wait <= (delay != 2'd0);
        if (dbus_req.wren) begin
          mem[word_index(dbus_req.address)] <= dbus_req.writedata;
          rd_pending <= 1'b0;
        end else if (delay == 2'd0) begin
          dbus_data_valid <= 1'b1;
          dbus_readdata   <= mem[word_index(dbus_req.address)];
          rd_pending      <= 1'b0;
        end else begin
          rd_pending <= 1'b1;
        end
      end else if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
        if (wait_left == 2'd1) begin
          dbus_wait <= 1'b0;
          if (rd_pending) begin
            dbus_data_valid <= 1'b1;
            dbus_readdata   <= mem[rd_index];
            rd_pending      <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// File: sim/tb_dma_subsystem.sv
`timescale 1ns/10ps
`include "dma_params.svh"

module tb_dma_subsystem;
  import dma_pkg::*;

  localparam string STIM_FILE = "sim/dma_stimulus.txt";
  localparam int CYCLES_PER_LINE = 200;

  logic        clk;
  logic        resetn;
  logic [7:0]  s_axil_awaddr;
  logic        s_axil_awvalid;
  logic        s_axil_awready;
  logic [31:0] s_axil_wdata;
  logic [3:0]  s_axil_wstrb;
  logic        s_axil_wvalid;
  logic        s_axil_wready;
  logic [1:0]  s_axil_bresp;
  logic        s_axil_bvalid;
  logic        s_axil_bready;
  logic [7:0]  s_axil_araddr;
  logic        s_axil_arvalid;
  logic        s_axil_arready;
  logic [31:0] s_axil_rdata;
  logic [1:0]  s_axil_rresp;
  logic        s_axil_rvalid;
  logic        s_axil_rready;
  dbus_req_t   dbus_req;
  bus_word_t   dbus_readdata;
  logic        dbus_wait;
  logic        dbus_data_valid;
  logic        irq;

  string       test_name = "none";
  int unsigned checks_run = 0;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  dma_subsystem u_dma_subsystem (
    .clk             (clk),
    .resetn          (resetn),
    .s_axil_awaddr   (s_axil_awaddr),
    .s_axil_awvalid  (s_axil_awvalid),
    .s_axil_awready  (s_axil_awready),
    .s_axil_wdata    (s_axil_wdata),
    .s_axil_wstrb    (s_axil_wstrb),
    .s_axil_wvalid   (s_axil_wvalid),
    .s_axil_wready   (s_axil_wready),
    .s_axil_bresp    (s_axil_bresp),
    .s_axil_bvalid   (s_axil_bvalid),
    .s_axil_bready   (s_axil_bready),
    .s_axil_araddr   (s_axil_araddr),
    .s_axil_arvalid  (s_axil_arvalid),
    .s_axil_arready  (s_axil_arready),
    .s_axil_rdata    (s_axil_rdata),
    .s_axil_rresp    (s_axil_rresp),
    .s_axil_rvalid   (s_axil_rvalid),
    .s_axil_rready   (s_axil_rready),
    .dbus_req        (dbus_req),
    .dbus_readdata   (dbus_readdata),
    .dbus_wait       (dbus_wait),
    .dbus_data_valid (dbus_data_valid),
    .irq             (irq)
  );

  dbus_memory_model u_dbus_memory_model (
    .clk             (clk),
    .resetn          (resetn),
    .dbus_req        (dbus_req),
    .dbus_readdata   (dbus_readdata),
    .dbus_wait       (dbus_wait),
    .dbus_data_valid (dbus_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ========================================
  // Failure handling and checks
  // ========================================
  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    stop_with_failure();
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Error: test %s, %s: expected %h, actual %h", test_name, what,
               expected, actual);
      stop_with_failure();
    end
    checks_run++;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
      $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
      stop_with_failure();
    end
  end

  // ========================================
  // AXI4-Lite driver
  // ========================================
  // Inputs change 1 ns after the edge, outputs are read there too
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic axil_write(input logic [7:0] off, input logic [31:0] data,
                            output logic [1:0] resp);
    s_axil_awaddr  = off;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wstrb   = 4'hf;
    s_axil_wvalid  = 1'b1;
    while (!(s_axil_awready && s_axil_wready)) step_cycle();
    step_cycle();
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;
    while (!s_axil_bvalid) step_cycle();
    resp = s_axil_bresp;
    step_cycle();
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] off, output logic [31:0] data,
                           output logic [1:0] resp);
    s_axil_araddr  = off;
    s_axil_arvalid = 1'b1;
    while (!s_axil_arready) step_cycle();
    step_cycle();
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    while (!s_axil_rvalid) step_cycle();
    data = s_axil_rdata;
    resp = s_axil_rresp;
    step_cycle();
    s_axil_rready = 1'b0;
  endtask

  task automatic poll_idle();
    logic [31:0] status;
    logic [1:0]  resp;
    status = 32'h1;
    while (status[0]) axil_read(`DMA_REG_STATUS, status, resp);
  endtask

  // ========================================
  // Stimulus file
  // ========================================
  task automatic count_lines(output int unsigned lines);
    int                 fd;
    logic [8*160-1:0]   line;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end
    lines = 0;
    while ($fgets(line, fd) != 0) lines++;
    $fclose(fd);
  endtask

  task automatic need_fields(input int got, input int want);
    if (got != want) begin
      abort_run("The stimulus file has a line with missing or bad values");
    end
  endtask

  task automatic run_stimulus();
    int               fd;
    int               code;
    logic             at_end;
    logic [7:0]       op;
    logic [8*32-1:0]  name_vec;
    logic [8*160-1:0] line;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [63:0]      c;
    logic [1:0]       resp;
    logic [31:0]      rd;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end
    at_end = 1'b0;
    while (!at_end) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        at_end = 1'b1;
      end else begin
        case (op)
          "#": code = $fgets(line, fd);
          "T": begin
            need_fields($fscanf(fd, "%s", name_vec), 1);
            test_name = $sformatf("%0s", name_vec);
          end
          "M": begin
            need_fields($fscanf(fd, "%h %h", a, b), 2);
            u_dbus_memory_model.preload(a[31:0], b);
          end
          "W": begin
            need_fields($fscanf(fd, "%h %h %h", a, b, c), 3);
            axil_write(a[7:0], b[31:0], resp);
            check_value("bresp", c, 64'(resp));
          end
          "R": begin
            need_fields($fscanf(fd, "%h %h", a, b), 2);
            axil_read(a[7:0], rd, resp);
            check_value("register read", b, 64'(rd));
            check_value("rresp", 64'd0, 64'(resp));
            if (a[7:0] == `DMA_REG_STATUS) begin
              // The interrupt follows the done bit of the status word
              check_value("irq", 64'(b[1]), 64'(irq));
            end
          end
          "P": poll_idle();
          "C": begin
            need_fields($fscanf(fd, "%h %h", a, b), 2);
            check_value("memory word", b, u_dbus_memory_model.peek(a[31:0]));
          end
          "N": begin
            need_fields($fscanf(fd, "%h", a), 1);
            check_value("bus requests", a, 64'(u_dbus_memory_model.req_count));
          end
          default: abort_run("The stimulus file has an unknown command");
        endcase
      end
    end
    $fclose(fd);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int unsigned lines;
    void'($urandom(32'hf67d_8fdc));
    resetn         = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    count_lines(lines);
    cycle_limit = lines * CYCLES_PER_LINE;
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
    check_value("irq after reset", 64'd0, 64'(irq));
    run_stimulus();
    if (checks_run != 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("No checks were run from the stimulus file");
      stop_with_failure();
    end
  end

endmodule

// File: flist.f
+incdir+source
source/dma_pkg.sv
source/dma_csr.sv
source/dma_engine.sv
source/dma_status.sv
source/lane_scratchpad.sv
source/dma_subsystem.sv
sim/dbus_memory_model.sv
sim/tb_dma_subsystem.sv

// File: Makefile
# Verilator build and run for the DMA subsystem testbench

VERILATOR  ?= verilator
TOP        ?= tb_dma_subsystem
RTL_TOP    ?= dma_subsystem
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
INC_DIRS   ?= +incdir+source
RTL_SRCS   ?= source/dma_pkg.sv source/dma_csr.sv source/dma_engine.sv \
              source/dma_status.sv source/lane_scratchpad.sv source/dma_subsystem.sv
PASS_MSG   ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(INC_DIRS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/dma_stimulus.txt
# Commands: T name | M addr data | W off data bresp | R off expect | P | C addr expect | N expect
# All numbers are hex, M and C use byte addresses on the memory bus
T reset
R 10 00000000
N 0
T round_trip
M 100 0123456789abcdef
M 108 1122334455667788
M 110 8899aabbccddeeff
M 118 0f1e2d3c4b5a6978
W 00 00000100 0
W 04 00000010 0
W 08 00000020 0
W 0c 00000001 0
P
R 10 00000102
N 4
W 10 00000002 0
R 10 00000100
W 00 00000200 0
W 08 00000020 0
W 0c 00000003 0
P
R 10 00000202
N 8
C 200 0123456789abcdef
C 208 1122334455667788
C 210 8899aabbccddeeff
C 218 0f1e2d3c4b5a6978
T lane_offset
W 00 00000300 0
W 04 00000011 0
W 08 00000010 0
W 0c 00000003 0
P
R 10 00000302
N a
C 300 1122334455667788
C 308 8899aabbccddeeff
T completion
W 10 00000002 0
R 10 00000300
W 20 00000001 2
T rejection
W 00 00000100 0
W 04 00000040 0
W 08 00000020 0
W 0c 00000001 0
W 0c 00000001 2
P
R 10 00000402
N e
T zero_length
W 10 00000002 0
R 10 00000400
W 08 00000000 0
W 0c 00000001 0
P
R 10 00000502
N e
